/* list.f */
logic/quiz_pkg.sv
logic/solver_pkg.sv
logic/solver_if.sv
logic/puzzle_picker.sv
logic/round_sequencer.sv
logic/elimination_unit.sv
logic/answer_checker.sv
logic/linear_quiz_top.sv
testbench/quiz_clock.sv
testbench/quiz_props.sv
testbench/quiz_tb.sv

/* logic/answer_checker.sv */
/*
 * answer checker
 * latches the entered x and y, compares them with the solved values
 */
`timescale 1ns/100ps
`default_nettype none

module answer_checker (
    input  logic                            Clock,
    input  logic                            reset,
    input  logic [quiz_pkg::data_width-1:0] data_in,
    solver_if.result                        bus,
    output logic                            done,
    output logic                            correct
);

    logic [quiz_pkg::data_width-1:0] x_answer;
    logic [quiz_pkg::data_width-1:0] y_answer;
    logic                            match;

    always_ff @(posedge Clock) begin
        if (bus.capture_x) begin
            x_answer <= data_in;
        end
        if (bus.capture_y) begin
            y_answer <= data_in;
        end
    end

    assign match = (x_answer == bus.solution_x) && (y_answer == bus.solution_y);

    always_ff @(posedge Clock) begin
        if (reset) begin
            done <= 1'b0;
            correct <= 1'b0;
        end else if (bus.load_puzzle) begin
            // new round clears the old verdict
            done <= 1'b0;
            correct <= 1'b0;
        end else if (bus.check) begin
            done <= 1'b1;
            correct <= match;
        end
    end

endmodule

`default_nettype wire

/* logic/elimination_unit.sv */
/*
 * elimination unit
 * coefficient and pivot registers, executes pivot, scale and eliminate ops
 */
`timescale 1ns/100ps
`default_nettype none

module elimination_unit (
    input  logic                            Clock,
    input  logic                            reset,
    input  logic [quiz_pkg::seed_width-1:0] puzzle_index,
    solver_if.unit                          bus
);

    // a1 b1 c1 a2 b2 c2
    logic [quiz_pkg::data_width-1:0] coef [quiz_pkg::coef_count];
    logic [quiz_pkg::data_width-1:0] pivot;

    logic [quiz_pkg::elem_index_width-1:0] target_idx;
    logic [quiz_pkg::elem_index_width-1:0] source_idx;
    logic [quiz_pkg::data_width-1:0]       target_val;
    logic [quiz_pkg::data_width-1:0]       source_val;
    logic [quiz_pkg::data_width-1:0]       product;
    logic [quiz_pkg::data_width-1:0]       alu_out;

    always_comb begin
        if (bus.op_kind == solver_pkg::op_eliminate) begin
            target_idx = bus.op_body.elim.target;
            source_idx = bus.op_body.elim.source;
        end else begin
            // pivot source sits in the scale target field
            target_idx = bus.op_body.scale.target;
            source_idx = bus.op_body.scale.target;
        end
    end

    assign target_val = coef[target_idx];
    assign source_val = coef[source_idx];

    // product wraps mod 256
    assign product = pivot * source_val;

    always_comb begin
        if (bus.op_kind == solver_pkg::op_scale) begin
            alu_out = target_val / pivot;
        end else begin
            alu_out = target_val - product;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < quiz_pkg::coef_count; i++) begin
                coef[i] <= '0;
            end
            pivot <= '0;
        end else if (bus.load_puzzle) begin
            for (int i = 0; i < quiz_pkg::coef_count; i++) begin
                coef[i] <= quiz_pkg::puzzle_table[puzzle_index][i];
            end
        end else if (bus.op_en) begin
            if (bus.op_kind == solver_pkg::op_pivot) begin
                pivot <= source_val;
            end else begin
                coef[target_idx] <= alu_out;
            end
        end
    end

    // c1 and c2 end up holding x and y
    assign bus.solution_x = coef[2];
    assign bus.solution_y = coef[5];

endmodule

`default_nettype wire

/* logic/linear_quiz_top.sv */
/*
 * linear equation quiz
 * picks a 2x2 system, solves it and grades the entered x and y
 */
`timescale 1ns/100ps
`default_nettype none

module linear_quiz_top (
    input  logic                             Clock,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             go,
    input  logic [quiz_pkg::timer_width-1:0] ongoing_timer,
    input  logic [quiz_pkg::data_width-1:0]  data_in,
    output logic                             done,
    output logic                             correct
);

    logic                            seed_load;
    logic                            step;
    logic [quiz_pkg::seed_width-1:0] puzzle_index;

    solver_if bus_i ();

    // seed comes from the low timer bits
    puzzle_picker picker_i (
        .Clock        (Clock),
        .reset        (reset),
        .seed_load    (seed_load),
        .step         (step),
        .seed         (ongoing_timer[quiz_pkg::seed_width-1:0]),
        .puzzle_index (puzzle_index)
    );

    round_sequencer sequencer_i (
        .Clock     (Clock),
        .reset     (reset),
        .start     (start),
        .go        (go),
        .seed_load (seed_load),
        .step      (step),
        .bus       (bus_i.sequencer)
    );

    elimination_unit unit_i (
        .Clock        (Clock),
        .reset        (reset),
        .puzzle_index (puzzle_index),
        .bus          (bus_i.unit)
    );

    answer_checker checker_i (
        .Clock   (Clock),
        .reset   (reset),
        .data_in (data_in),
        .bus     (bus_i.result),
        .done    (done),
        .correct (correct)
    );

endmodule

`default_nettype wire

/* logic/puzzle_picker.sv */
/*
 * puzzle picker
 * captures a timer seed, steps a 3-bit LFSR once and maps it to a puzzle
 */
`timescale 1ns/100ps
`default_nettype none

module puzzle_picker (
    input  logic                            Clock,
    input  logic                            reset,
    input  logic                            seed_load,
    input  logic                            step,
    input  logic [quiz_pkg::seed_width-1:0] seed,
    output logic [quiz_pkg::seed_width-1:0] puzzle_index
);

    logic [quiz_pkg::seed_width-1:0] lfsr;
    logic [quiz_pkg::seed_width-1:0] lfsr_next;
    logic                            feedback;

    assign feedback = lfsr[1] ^ lfsr[2];

    always_comb begin
        lfsr_next[0] = lfsr[2];
        lfsr_next[1] = feedback;
        lfsr_next[2] = feedback;
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            lfsr <= 3'd1;
        end else if (seed_load) begin
            // all-zero would lock the LFSR
            if (seed == '0) begin
                lfsr <= 3'd1;
            end else begin
                lfsr <= seed;
            end
        end else if (step) begin
            lfsr <= lfsr_next;
        end
    end

    assign puzzle_index = quiz_pkg::lfsr_to_puzzle[lfsr];

endmodule

`default_nettype wire

/* logic/quiz_pkg.sv */
/*
 * quiz constants
 * data widths, the stored 2x2 systems and the LFSR to puzzle map
 */
`default_nettype none

package quiz_pkg;

    localparam int data_width = 8;
    localparam int seed_width = 3;
    localparam int timer_width = 7;
    localparam int puzzle_count = 5;
    localparam int coef_count = 6;
    localparam int elem_index_width = 3;

    // a1 b1 c1 a2 b2 c2 per entry
    localparam logic [data_width-1:0] puzzle_table [puzzle_count][coef_count] = '{
        '{8'd2, 8'd2, 8'd10, 8'd1, 8'd4, 8'd8},
        '{8'd2, 8'd5, 8'd14, 8'd3, 8'd24, 8'd21},
        '{8'd2, 8'd2, 8'd12, 8'd2, 8'd6, 8'd24},
        '{8'd8, 8'd3, 8'd6, 8'd3, 8'd2, 8'd4},
        '{8'd7, 8'd2, 8'd2, 8'd1, 8'd9, 8'd9}
    };

    // pairs of LFSR values share an entry, 6 and 7 get their own
    localparam logic [seed_width-1:0] lfsr_to_puzzle [2**seed_width] = '{
        3'd0,
        3'd0,
        3'd1,
        3'd1,
        3'd2,
        3'd2,
        3'd3,
        3'd4
    };

endpackage

`default_nettype wire

/* logic/round_sequencer.sv */
/*
 * round sequencer
 * round FSM plus the Gauss-Jordan micro-op schedule for the solver
 */
`timescale 1ns/100ps
`default_nettype none

module round_sequencer (
    input  logic        Clock,
    input  logic        reset,
    input  logic        start,
    input  logic        go,
    output logic        seed_load,
    output logic        step,
    solver_if.sequencer bus
);

    solver_pkg::round_state_e state;
    solver_pkg::round_state_e next_state;

    logic [3:0]                            solve_count;
    logic [1:0]                            phase;
    logic [1:0]                            slot;
    logic [quiz_pkg::elem_index_width-1:0] col;

    always_comb begin
        next_state = state;
        case (state)
            solver_pkg::state_idle:     if (start) next_state = solver_pkg::state_seed;
            solver_pkg::state_seed:     next_state = solver_pkg::state_step;
            solver_pkg::state_step:     next_state = solver_pkg::state_load;
            solver_pkg::state_load:     next_state = solver_pkg::state_enter_x;
            solver_pkg::state_enter_x:  if (go) next_state = solver_pkg::state_wait_x;
            solver_pkg::state_wait_x:   if (!go) next_state = solver_pkg::state_enter_y;
            solver_pkg::state_enter_y:  if (go) next_state = solver_pkg::state_wait_y;
            solver_pkg::state_wait_y:   if (!go) next_state = solver_pkg::state_solve;
            solver_pkg::state_solve: begin
                if (solve_count == 4'(solver_pkg::solve_cycles - 1)) begin
                    next_state = solver_pkg::state_compare;
                end
            end
            solver_pkg::state_compare:  next_state = solver_pkg::state_finished;
            // a new start skips idle
            solver_pkg::state_finished: if (start) next_state = solver_pkg::state_seed;
            default:                    next_state = solver_pkg::state_idle;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            state <= solver_pkg::state_idle;
            solve_count <= '0;
        end else begin
            state <= next_state;
            if (state == solver_pkg::state_solve) begin
                solve_count <= solve_count + 4'd1;
            end else begin
                solve_count <= '0;
            end
        end
    end

    assign seed_load = (state == solver_pkg::state_seed);
    assign step = (state == solver_pkg::state_step);
    assign bus.load_puzzle = (state == solver_pkg::state_load);
    assign bus.capture_x = (state == solver_pkg::state_enter_x) && go;
    assign bus.capture_y = (state == solver_pkg::state_enter_y) && go;
    assign bus.check = (state == solver_pkg::state_compare);
    assign bus.op_en = (state == solver_pkg::state_solve);

    // four phases of one pivot and three element ops
    assign phase = solve_count[3:2];
    assign slot = solve_count[1:0];
    assign col = {1'b0, slot} - 1'b1;

    always_comb begin
        bus.op_kind = solver_pkg::op_pivot;
        bus.op_body = '0;
        if (slot == 2'd0) begin
            // pivots are a1, a2, b2, b1 in turn
            case (phase)
                2'd0:    bus.op_body.scale.target = 3'd0;
                2'd1:    bus.op_body.scale.target = 3'd3;
                2'd2:    bus.op_body.scale.target = 3'd4;
                default: bus.op_body.scale.target = 3'd1;
            endcase
            bus.op_body.scale.spare = '0;
        end else begin
            case (phase)
                2'd0: begin
                    bus.op_kind = solver_pkg::op_scale;
                    bus.op_body.scale.target = col;
                    bus.op_body.scale.spare = '0;
                end
                2'd1: begin
                    bus.op_kind = solver_pkg::op_eliminate;
                    bus.op_body.elim.target = col + 3'd3;
                    bus.op_body.elim.source = col;
                end
                2'd2: begin
                    bus.op_kind = solver_pkg::op_scale;
                    bus.op_body.scale.target = col + 3'd3;
                    bus.op_body.scale.spare = '0;
                end
                default: begin
                    bus.op_kind = solver_pkg::op_eliminate;
                    bus.op_body.elim.target = col;
                    bus.op_body.elim.source = col + 3'd3;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/solver_if.sv */
/*
 * solver bus
 * links the round sequencer, elimination unit and answer checker
 */
`timescale 1ns/100ps
`default_nettype none

interface solver_if;

    logic                                op_en;
    solver_pkg::op_kind_e                op_kind;
    solver_pkg::micro_op_body_u          op_body;
    logic                                load_puzzle;
    logic                                capture_x;
    logic                                capture_y;
    logic                                check;
    logic [quiz_pkg::data_width-1:0]     solution_x;
    logic [quiz_pkg::data_width-1:0]     solution_y;

    modport sequencer (
        output op_en, op_kind, op_body, load_puzzle, capture_x, capture_y, check
    );

    modport unit (
        input  op_en, op_kind, op_body, load_puzzle,
        output solution_x, solution_y
    );

    // answer checker side
    modport result (
        input capture_x, capture_y, check, load_puzzle, solution_x, solution_y
    );

endinterface

`default_nettype wire

/* logic/solver_pkg.sv */
/*
 * solver types
 * micro-op kinds and body views, round state encoding
 */
`default_nettype none

package solver_pkg;

    localparam int solve_cycles = 16;

    typedef enum logic [1:0] {
        op_pivot     = 2'd0,
        op_scale     = 2'd1,
        op_eliminate = 2'd2
    } op_kind_e;

    // pivot ops carry their source in the scale target field
    typedef struct packed {
        logic [quiz_pkg::elem_index_width-1:0] target;
        logic [quiz_pkg::elem_index_width-1:0] spare;
    } scale_view_t;

    typedef struct packed {
        logic [quiz_pkg::elem_index_width-1:0] target;
        logic [quiz_pkg::elem_index_width-1:0] source;
    } elim_view_t;

    typedef union packed {
        scale_view_t scale;
        elim_view_t  elim;
    } micro_op_body_u;

    typedef enum logic [4:0] {
        state_idle     = 5'd0,
        state_seed     = 5'd1,
        state_step     = 5'd2,
        state_load     = 5'd3,
        state_enter_x  = 5'd4,
        state_wait_x   = 5'd5,
        state_enter_y  = 5'd6,
        state_wait_y   = 5'd7,
        state_solve    = 5'd8,
        state_compare  = 5'd9,
        state_finished = 5'd10
    } round_state_e;

endpackage

`default_nettype wire

/* testbench/quiz_clock.sv */
/*
 * quiz clock
 * free-running 10 ns clock for the testbench
 */
`timescale 1ns/100ps
`default_nettype none

module quiz_clock (
    output logic Clock
);

    initial Clock = 1'b0;

    // half period
    always #5 Clock = ~Clock;

endmodule

`default_nettype wire

/* testbench/quiz_props.sv */
/*
 * quiz properties
 * assertions on done and correct, bound into the quiz top level
 */
`timescale 1ns/100ps
`default_nettype none

module quiz_props (
    input logic Clock,
    input logic reset,
    input logic start,
    input logic done,
    input logic correct
);

    // failed assertions so far
    int failures = 0;

    correct_needs_done: assert property (
        @(posedge Clock) disable iff (reset) correct |-> done
    ) else begin
        $error("correct is high while done is low");
        failures++;
    end

    done_low_after_reset: assert property (
        @(posedge Clock) reset |=> !done
    ) else begin
        $error("done is high in the cycle after reset");
        failures++;
    end

    // start reaches the verdict clear through seed, step and load
    done_falls_on_start: assert property (
        @(posedge Clock) disable iff (reset) $fell(done) |-> $past(start, 4)
    ) else begin
        $error("done fell without a start");
        failures++;
    end

endmodule

bind linear_quiz_top quiz_props props_i (
    .Clock   (Clock),
    .reset   (reset),
    .start   (start),
    .done    (done),
    .correct (correct)
);

`default_nettype wire

/* testbench/quiz_tb.sv */
/*
 * quiz testbench
 * plays table-driven rounds and grades done, correct and the solved values
 */
`timescale 1ns/100ps
`default_nettype none

module quiz_tb;

    typedef struct packed {
        logic [6:0] timer;
        logic       rand_timer;
        logic [7:0] x_delta;
        logic [7:0] y_delta;
        logic [2:0] hold;
        logic       exp_correct;
    } row_t;

    localparam int row_count = 14;

    // timer, random timer, x offset, y offset, go hold cycles, expected correct
    localparam row_t rows [row_count] = '{
        '{7'h01, 1'b0, 8'd0, 8'd0, 3'd0, 1'b1},
        '{7'h02, 1'b0, 8'd0, 8'd0, 3'd0, 1'b1},
        '{7'h03, 1'b0, 8'd0, 8'd0, 3'd0, 1'b1},
        '{7'h04, 1'b0, 8'd0, 8'd0, 3'd0, 1'b1},
        '{7'h05, 1'b0, 8'd0, 8'd0, 3'd0, 1'b1},
        '{7'h06, 1'b0, 8'd0, 8'd0, 3'd0, 1'b1},
        '{7'h07, 1'b0, 8'd0, 8'd0, 3'd0, 1'b1},
        '{7'h01, 1'b0, 8'd1, 8'd0, 3'd0, 1'b0},
        '{7'h04, 1'b0, 8'd0, 8'hff, 3'd0, 1'b0},
        '{7'h48, 1'b0, 8'd0, 8'd0, 3'd0, 1'b1},
        '{7'h16, 1'b0, 8'd0, 8'd0, 3'd3, 1'b1},
        '{7'h00, 1'b1, 8'd0, 8'd0, 3'd0, 1'b1},
        '{7'h00, 1'b1, 8'd2, 8'd0, 3'd0, 1'b0},
        '{7'h00, 1'b1, 8'd0, 8'd0, 3'd2, 1'b1}
    };

    logic       Clock;
    logic       reset;
    logic       start;
    logic       go;
    logic [6:0] ongoing_timer;
    logic [7:0] data_in;
    logic       done;
    logic       correct;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'hc526;

    quiz_clock clock_i (.Clock(Clock));

    linear_quiz_top dut_i (
        .Clock         (Clock),
        .reset         (reset),
        .start         (start),
        .go            (go),
        .ongoing_timer (ongoing_timer),
        .data_in       (data_in),
        .done          (done),
        .correct       (correct)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // zero seed acts as 1, one LFSR step, then the value to entry map
    function automatic int puzzle_for_seed(input logic [2:0] seed);
        logic [2:0] s;
        logic [2:0] n;
        s = (seed == 3'd0) ? 3'd1 : seed;
        n = {s[2] ^ s[1], s[2] ^ s[1], s[2]};
        if (n < 3'd6) begin
            return int'(n) / 2;
        end else begin
            return (n == 3'd6) ? 3 : 4;
        end
    endfunction

    task automatic solve_entry(input int entry, output logic [7:0] x, output logic [7:0] y);
        logic [7:0] m [6];
        logic [7:0] p;
        for (int i = 0; i < 6; i++) begin
            m[i] = quiz_pkg::puzzle_table[entry][i];
        end
        p = m[0];
        for (int i = 0; i < 3; i++) begin
            m[i] = m[i] / p;
        end
        p = m[3];
        for (int i = 0; i < 3; i++) begin
            m[i + 3] = m[i + 3] - p * m[i];
        end
        p = m[4];
        for (int i = 3; i < 6; i++) begin
            m[i] = m[i] / p;
        end
        p = m[1];
        for (int i = 0; i < 3; i++) begin
            m[i] = m[i] - p * m[i + 3];
        end
        x = m[2];
        y = m[5];
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at %0t: %s got %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    // done must be cleared by the time the round reaches enter_x
    task automatic start_round(input logic [6:0] timer);
        @(posedge Clock);
        ongoing_timer <= timer;
        start <= 1'b1;
        @(posedge Clock);
        start <= 1'b0;
        repeat (3) @(posedge Clock);
        @(negedge Clock);
        check_value("done", done, 1'b0);
        check_value("correct", correct, 1'b0);
    endtask

    task automatic enter_value(input logic [7:0] value, input int hold);
        @(posedge Clock);
        go <= 1'b1;
        data_in <= value;
        // later values while go stays high must be ignored
        for (int i = 0; i < hold; i++) begin
            @(posedge Clock);
            data_in <= value + 8'h35 + 8'(i);
        end
        @(posedge Clock);
        go <= 1'b0;
    endtask

    task automatic wait_for_done(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < 60) begin
            @(negedge Clock);
            seen = done;
            cycles++;
        end
        if (!seen) begin
            errors++;
            $display("Error at %0t: done did not rise after both answers", $time);
        end
    endtask

    initial begin
        int         entry;
        int         assert_failures;
        logic [6:0] timer;
        logic [7:0] sol_x;
        logic [7:0] sol_y;
        bit         seen;

        reset <= 1'b1;
        start <= 1'b0;
        go <= 1'b0;
        ongoing_timer <= '0;
        data_in <= '0;
        repeat (5) @(posedge Clock);
        reset <= 1'b0;

        // model sanity on entry 0
        solve_entry(0, sol_x, sol_y);
        check_value("model_x", sol_x, 8'd4);
        check_value("model_y", sol_y, 8'd1);

        // idle after reset
        repeat (8) begin
            @(negedge Clock);
            check_value("done", done, 1'b0);
            check_value("correct", correct, 1'b0);
        end

        for (int r = 0; r < row_count; r++) begin
            timer = rows[r].timer;
            if (rows[r].rand_timer) begin
                rng_state = xorshift32(rng_state);
                timer = rng_state[6:0];
            end
            entry = puzzle_for_seed(timer[2:0]);
            solve_entry(entry, sol_x, sol_y);
            start_round(timer);
            enter_value(sol_x + rows[r].x_delta, rows[r].hold);
            enter_value(sol_y + rows[r].y_delta, rows[r].hold);
            wait_for_done(seen);
            if (seen) begin
                check_value("correct", correct, rows[r].exp_correct);
                check_value("solution_x", dut_i.bus_i.solution_x, sol_x);
                check_value("solution_y", dut_i.bus_i.solution_y, sol_y);
            end
        end

        repeat (2) @(posedge Clock);
        assert_failures = dut_i.props_i.failures;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (row_count * 200) @(posedge Clock);
        $display("Timeout: the rounds did not finish within %0d cycles", row_count * 200);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
